// File: Bender.yml
package:
  name: aes128

sources:
  # shared package first
  - common/aes_pkg.sv
  - src/aes_req_fifo.sv
  - aes/aes_key_memory.sv
  - aes/aes_encryption.sv
  - aes/aes_decryption.sv
  - aes/aes_core.sv
  - src/aes_top.sv
  # testbench
  - target: test
    files:
      - tests/aes_clk_gen.sv
      - tests/aes_checker.sv
      - tests/aes_chk.sv
      - tests/aes_tb.sv

// File: aes/aes_core.sv
// one-block-at-a-time AES-128 core, sequences key schedule, engine and held response
`default_nettype none

module aes_core import aes_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      in_valid,
  output logic      in_ready,
  input  aes_req_t  in_req,
  output logic      resp_valid,
  input  logic      resp_ready,
  output aes_resp_t resp
);

  // ====================
  // internal wiring
  // ====================

  aes_req_t     req_q;
  logic [1:0]   state;
  logic [3:0]   round;
  logic [3:0]   key_round;
  logic [127:0] round_key;

  logic key_init;
  logic key_expanded;
  logic eng_init;
  logic is_enc;

  logic enc_next, dec_next, next_round;
  logic enc_done, dec_done, done;
  aes_block_u enc_result, dec_result;

  assign in_ready = (state == st_idle);
  assign is_enc   = (req_q.mode == mode_encrypt);

  // decryption walks the schedule backwards
  assign key_round  = is_enc ? round : 4'(aes_num_rounds) - round;
  assign next_round = is_enc ? enc_next : dec_next;
  assign done       = is_enc ? enc_done : dec_done;

  aes_key_memory u_key_memory (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .init         (key_init),
    .key          (req_q.key),
    .round_rd     (key_round),
    .round_key    (round_key),
    .key_expanded (key_expanded)
  );

  aes_encryption u_encryption (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .init       (eng_init & is_enc),
    .data       (req_q.data),
    .round_key  (round_key),
    .next_round (enc_next),
    .done       (enc_done),
    .result     (enc_result)
  );

  aes_decryption u_decryption (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .init       (eng_init & (req_q.mode == mode_decrypt)),
    .data       (req_q.data),
    .round_key  (round_key),
    .next_round (dec_next),
    .done       (dec_done),
    .result     (dec_result)
  );

  // ====================
  // sequencing FSM
  // ====================

  always_ff @(posedge clk_in) begin
    if (in_valid && in_ready) begin
      req_q <= in_req;
    end
    // capture result as the engine finishes
    if (state == st_running && done) begin
      resp.mode <= req_q.mode;
      resp.data <= is_enc ? enc_result : dec_result;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= st_idle;
      round      <= 4'd0;
      key_init   <= 1'b0;
      eng_init   <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      key_init <= 1'b0;
      eng_init <= 1'b0;
      case (state)
        st_idle: begin
          if (in_valid) begin
            key_init <= 1'b1;
            state    <= st_expanding;
          end
        end
        st_expanding: begin
          // engine starts one cycle after the last key lands
          if (key_expanded) begin
            eng_init <= 1'b1;
            round    <= 4'd0;
            state    <= st_running;
          end
        end
        st_running: begin
          if (next_round) begin
            round <= round + 1'b1;
          end
          if (done) begin
            resp_valid <= 1'b1;
            state      <= st_holding;
          end
        end
        default: begin
          // hold until the response transfers
          if (resp_ready) begin
            resp_valid <= 1'b0;
            state      <= st_idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: aes/aes_decryption.sv
// iterative AES inverse cipher, round keys are fed from key 10 down to key 0
`default_nettype none

module aes_decryption import aes_pkg::*; (
  input  logic         clk_in,
  input  logic         rst_in,
  input  logic         init,
  input  aes_block_u   data,
  input  logic [127:0] round_key,
  output logic         next_round,
  output logic         done,
  output aes_block_u   result
);

  aes_block_u state_q;
  aes_block_u ishift_s;
  aes_block_u isub_s;
  aes_block_u add_s;
  aes_block_u imix_s;
  aes_block_u next_s;

  logic [3:0] rnd;
  logic       busy;
  logic       last;

  assign last   = (rnd == 4'(aes_num_rounds));
  assign result = state_q;

  // high on the load and on every round
  assign next_round = init | busy;

  always_comb begin
    // InvShiftRows, row r rotates right by r
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        ishift_s.bytes[15 - (r + 4 * c)] = state_q.bytes[15 - (r + 4 * ((c + 4 - r) % 4))];
      end
    end
    // InvSubBytes
    for (int i = 0; i < 16; i++) begin
      isub_s.bytes[i] = aes_inv_sbox(ishift_s.bytes[i]);
    end
    // AddRoundKey before the column step
    add_s = isub_s ^ round_key;
    for (int j = 0; j < 4; j++) begin
      imix_s.cols[j] = aes_inv_mix_col(add_s.cols[j]);
    end
    next_s = last ? add_s : imix_s;
  end

  always_ff @(posedge clk_in) begin
    if (init) begin
      state_q <= data ^ round_key;
    end else if (busy) begin
      state_q <= next_s;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= 1'b0;
      rnd  <= 4'd0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (init) begin
        busy <= 1'b1;
        rnd  <= 4'd1;
      end else if (busy) begin
        rnd <= rnd + 1'b1;
        if (last) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: aes/aes_encryption.sv
// iterative AES forward cipher, initial AddRoundKey then one round per clock
`default_nettype none

module aes_encryption import aes_pkg::*; (
  input  logic         clk_in,
  input  logic         rst_in,
  input  logic         init,
  input  aes_block_u   data,
  input  logic [127:0] round_key,
  output logic         next_round,
  output logic         done,
  output aes_block_u   result
);

  aes_block_u state_q;
  aes_block_u sub_s;
  aes_block_u shift_s;
  aes_block_u mix_s;
  aes_block_u next_s;

  // round executed at the coming edge
  logic [3:0] rnd;
  logic       busy;
  logic       last;

  assign last   = (rnd == 4'(aes_num_rounds));
  assign result = state_q;

  // the core steps its key index on every step, the load included
  assign next_round = init | busy;

  always_comb begin
    // SubBytes
    for (int i = 0; i < 16; i++) begin
      sub_s.bytes[i] = aes_sbox(state_q.bytes[i]);
    end
    // ShiftRows, row r rotates left by r
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shift_s.bytes[15 - (r + 4 * c)] = sub_s.bytes[15 - (r + 4 * ((c + r) % 4))];
      end
    end
    // MixColumns
    for (int j = 0; j < 4; j++) begin
      mix_s.cols[j] = aes_mix_col(shift_s.cols[j]);
    end
    // final round drops MixColumns
    next_s = (last ? shift_s : mix_s) ^ round_key;
  end

  always_ff @(posedge clk_in) begin
    if (init) begin
      state_q <= data ^ round_key;
    end else if (busy) begin
      state_q <= next_s;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= 1'b0;
      rnd  <= 4'd0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (init) begin
        busy <= 1'b1;
        rnd  <= 4'd1;
      end else if (busy) begin
        rnd <= rnd + 1'b1;
        if (last) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: aes/aes_key_memory.sv
// AES-128 key schedule, one round key per clock, eleven keys held for read by round index
`default_nettype none

module aes_key_memory import aes_pkg::*; (
  input  logic         clk_in,
  input  logic         rst_in,
  input  logic         init,
  input  logic [127:0] key,
  input  logic [3:0]   round_rd,
  output logic [127:0] round_key,
  output logic         key_expanded
);

  logic [127:0] keys [aes_num_rounds + 1];

  // index of the key being derived this cycle
  logic [3:0] idx;
  logic       busy;
  logic [7:0] rcon;

  aes_block_u prev;
  aes_block_u next;
  logic [31:0] temp;

  // out-of-range reads return zero
  assign round_key = (round_rd > 4'(aes_num_rounds)) ? 128'h0 : keys[round_rd];

  // w0 is the top column, w3 the bottom one
  always_comb begin
    prev.cols = keys[idx - 1'b1];
    // RotWord then SubWord, then the round constant on the top byte
    temp = {aes_sbox(prev.cols[0][23:16]), aes_sbox(prev.cols[0][15:8]),
            aes_sbox(prev.cols[0][7:0]), aes_sbox(prev.cols[0][31:24])};
    temp = temp ^ {rcon, 24'h0};
    next.cols[3] = prev.cols[3] ^ temp;
    next.cols[2] = prev.cols[2] ^ next.cols[3];
    next.cols[1] = prev.cols[1] ^ next.cols[2];
    next.cols[0] = prev.cols[0] ^ next.cols[1];
  end

  always_ff @(posedge clk_in) begin
    if (init) begin
      keys[0] <= key;
    end else if (busy) begin
      keys[idx] <= next.cols;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy         <= 1'b0;
      idx          <= 4'd0;
      rcon         <= 8'h01;
      key_expanded <= 1'b0;
    end else begin
      key_expanded <= 1'b0;
      if (init) begin
        busy <= 1'b1;
        idx  <= 4'd1;
        rcon <= 8'h01;
      end else if (busy) begin
        idx  <= idx + 1'b1;
        rcon <= aes_xtime(rcon);
        // key 10 lands this edge
        if (idx == 4'(aes_num_rounds)) begin
          busy         <= 1'b0;
          key_expanded <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: common/aes_pkg.sv
// shared AES-128 sizes, FSM codes, block types and GF(2^8) helpers, pulled in with aes_pkg::*
`default_nettype none

package aes_pkg;

  // ====================
  // sizes and encodings
  // ====================

  // fixed by the AES-128 standard
  localparam int unsigned aes_num_rounds = 10;
  // request buffer entries
  localparam int unsigned aes_fifo_depth = 4;

  // mode bit values
  localparam logic mode_encrypt = 1'b1;
  localparam logic mode_decrypt = 1'b0;

  // cipher core FSM codes
  localparam logic [1:0] st_idle      = 2'd0;
  localparam logic [1:0] st_expanding = 2'd1;
  localparam logic [1:0] st_running   = 2'd2;
  localparam logic [1:0] st_holding   = 2'd3;

  // ====================
  // block and port types
  // ====================

  // AES byte 0 sits in the top byte, so AES byte i is bytes[15-i]
  // and AES column c is cols[3-c]
  typedef union packed {
    logic [15:0][7:0] bytes;
    logic [3:0][31:0] cols;
  } aes_block_u;

  typedef struct packed {
    logic       mode;
    aes_block_u data;
    logic [127:0] key;
  } aes_req_t;

  typedef struct packed {
    logic       mode;
    aes_block_u data;
  } aes_resp_t;

  // ====================
  // field arithmetic
  // ====================

  // multiply by x modulo the AES polynomial
  function automatic logic [7:0] aes_xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // shift-and-add multiply
  function automatic logic [7:0] aes_gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] t;
    p = 8'h00;
    t = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        p = p ^ t;
      end
      t = aes_xtime(t);
    end
    return p;
  endfunction

  // inverse as b^254, zero maps to zero on its own
  function automatic logic [7:0] aes_gf_inv(input logic [7:0] b);
    logic [7:0] r;
    r = b;
    // walks b^3, b^7 ... up to b^127
    for (int i = 0; i < 6; i++) begin
      r = aes_gf_mul(aes_gf_mul(r, r), b);
    end
    return aes_gf_mul(r, r);
  endfunction

  function automatic logic [7:0] aes_rotl8(input logic [7:0] b, input int n);
    logic [15:0] t;
    t = {b, b} << n;
    return t[15:8];
  endfunction

  // inverse then affine map
  function automatic logic [7:0] aes_sbox(input logic [7:0] b);
    logic [7:0] v;
    v = aes_gf_inv(b);
    return v ^ aes_rotl8(v, 1) ^ aes_rotl8(v, 2) ^ aes_rotl8(v, 3) ^ aes_rotl8(v, 4) ^ 8'h63;
  endfunction

  // undo the affine map then invert
  function automatic logic [7:0] aes_inv_sbox(input logic [7:0] s);
    logic [7:0] v;
    v = aes_rotl8(s, 1) ^ aes_rotl8(s, 3) ^ aes_rotl8(s, 6) ^ 8'h05;
    return aes_gf_inv(v);
  endfunction

  // one column, top byte is row 0
  function automatic logic [31:0] aes_mix_col(input logic [31:0] c);
    logic [7:0] a0, a1, a2, a3;
    {a0, a1, a2, a3} = c;
    return {aes_xtime(a0) ^ aes_xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ aes_xtime(a1) ^ aes_xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ aes_xtime(a2) ^ aes_xtime(a3) ^ a3,
            aes_xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_xtime(a3)};
  endfunction

  // coefficients 0e 0b 0d 09, rotated per row
  function automatic logic [31:0] aes_inv_mix_col(input logic [31:0] c);
    logic [7:0] a0, a1, a2, a3;
    {a0, a1, a2, a3} = c;
    return {aes_gf_mul(a0, 8'h0e) ^ aes_gf_mul(a1, 8'h0b) ^
            aes_gf_mul(a2, 8'h0d) ^ aes_gf_mul(a3, 8'h09),
            aes_gf_mul(a0, 8'h09) ^ aes_gf_mul(a1, 8'h0e) ^
            aes_gf_mul(a2, 8'h0b) ^ aes_gf_mul(a3, 8'h0d),
            aes_gf_mul(a0, 8'h0d) ^ aes_gf_mul(a1, 8'h09) ^
            aes_gf_mul(a2, 8'h0e) ^ aes_gf_mul(a3, 8'h0b),
            aes_gf_mul(a0, 8'h0b) ^ aes_gf_mul(a1, 8'h0d) ^
            aes_gf_mul(a2, 8'h09) ^ aes_gf_mul(a3, 8'h0e)};
  endfunction

endpackage

`default_nettype wire

// File: list.f
common/aes_pkg.sv
src/aes_req_fifo.sv
aes/aes_key_memory.sv
aes/aes_encryption.sv
aes/aes_decryption.sv
aes/aes_core.sv
src/aes_top.sv
tests/aes_clk_gen.sv
tests/aes_checker.sv
tests/aes_chk.sv
tests/aes_tb.sv

// File: src/aes_req_fifo.sv
// four-entry request queue between the caller's valid/ready port and the cipher core
`default_nettype none

module aes_req_fifo import aes_pkg::*; (
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     in_valid,
  output logic     in_ready,
  input  aes_req_t in_req,
  output logic     out_valid,
  input  logic     out_ready,
  output aes_req_t out_req
);

  // request storage
  aes_req_t mem [aes_fifo_depth];

  logic [$clog2(aes_fifo_depth)-1:0] wr_ptr;
  logic [$clog2(aes_fifo_depth)-1:0] rd_ptr;
  // one extra bit so full is distinct from empty
  logic [$clog2(aes_fifo_depth):0]   count;

  logic push;
  logic pop;

  assign in_ready  = (count != aes_fifo_depth);
  assign out_valid = (count != 0);
  assign out_req   = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clk_in) begin
    if (push) begin
      mem[wr_ptr] <= in_req;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/aes_top.sv
// AES-128 unit top, request FIFO in front of the iterative cipher core
`default_nettype none

module aes_top import aes_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      req_valid,
  output logic      req_ready,
  input  aes_req_t  req,
  output logic      resp_valid,
  input  logic      resp_ready,
  output aes_resp_t resp
);

  // FIFO to core
  logic     fifo_valid;
  logic     fifo_ready;
  aes_req_t fifo_req;

  aes_req_fifo u_req_fifo (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .in_req    (req),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready),
    .out_req   (fifo_req)
  );

  aes_core u_core (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .in_valid   (fifo_valid),
    .in_ready   (fifo_ready),
    .in_req     (fifo_req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
  );

endmodule

`default_nettype wire

// File: tests/aes_checker.sv
// response monitor for the AES unit testbench, compares transfers in order and counts errors
`default_nettype none

module aes_checker import aes_pkg::*; (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            req_ready,
  input  logic            resp_valid,
  input  logic            resp_ready,
  input  aes_resp_t       resp,
  input  aes_resp_t [7:0] expected,
  output int              resp_count,
  output int              value_errors,
  output int              protocol_errors,
  output logic            full_seen
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_vectors = 8;

  // response that was offered without ready on the last edge
  logic      prev_hold;
  aes_resp_t prev_resp;

  function automatic string test_name(input int idx, input logic mode);
    return $sformatf("vector_%0d_%s", idx, (mode == mode_encrypt) ? "enc" : "dec");
  endfunction

  // mode and data compared on their own, returns the number of mismatches
  function automatic int compare_resp(input int idx, input aes_resp_t exp, input aes_resp_t act);
    int bad;
    bad = 0;
    if (act.mode !== exp.mode) begin
      $display("FAIL %s mode: expected %0d actual %0d",
               test_name(idx, exp.mode), exp.mode, act.mode);
      bad++;
    end
    if (act.data !== exp.data) begin
      $display("FAIL %s data: expected %h actual %h",
               test_name(idx, exp.mode), exp.data, act.data);
      bad++;
    end
    return bad;
  endfunction

  initial begin
    resp_count      = 0;
    value_errors    = 0;
    protocol_errors = 0;
    full_seen       = 1'b0;
    prev_hold       = 1'b0;
  end

  always @(posedge clk_in) begin : watch
    int proto;
    proto = 0;
    if (rst_in) begin
      prev_hold <= 1'b0;
    end else begin
      // FIFO reported full at least once
      if (!req_ready) begin
        full_seen <= 1'b1;
      end
      // a held response must neither drop nor change
      if (prev_hold && (!resp_valid || resp !== prev_resp)) begin
        $display("resp_valid dropped or resp changed before transfer of response %0d",
                 resp_count);
        proto++;
      end
      if (resp_valid && resp_ready) begin
        if (resp_count >= num_vectors) begin
          $display("unexpected extra response after %0d responses", resp_count);
          proto++;
        end else begin
          value_errors <= value_errors + compare_resp(resp_count, expected[resp_count], resp);
        end
        resp_count <= resp_count + 1;
      end
      protocol_errors <= protocol_errors + proto;
      prev_hold       <= resp_valid && !resp_ready;
      prev_resp       <= resp;
    end
  end

endmodule

`default_nettype wire

// File: tests/aes_chk.sv
// handshake assertions on the AES unit ports, attached to the top level with bind
`default_nettype none

module aes_chk import aes_pkg::*; (
  input logic      clk_in,
  input logic      rst_in,
  input logic      req_ready,
  input logic      resp_valid,
  input logic      resp_ready,
  input aes_resp_t resp
);
  timeunit 1ns;
  timeprecision 100ps;

  // failed assertions, read by the testbench at the end
  int assert_errors = 0;

  // first edge out of reset sees an empty response side and a FIFO with room
  reset_state: assert property (@(posedge clk_in) $fell(rst_in) |-> !resp_valid && req_ready)
    else begin
      $error("resp_valid high or req_ready low on the first cycle after reset");
      assert_errors++;
    end

  // offered response stays offered until taken
  valid_held: assert property (@(posedge clk_in) disable iff (rst_in)
    resp_valid && !resp_ready |=> resp_valid)
    else begin
      $error("resp_valid dropped before the response was accepted");
      assert_errors++;
    end

  // payload frozen while waiting
  resp_held: assert property (@(posedge clk_in) disable iff (rst_in)
    resp_valid && !resp_ready |=> $stable(resp))
    else begin
      $error("resp changed while waiting for resp_ready");
      assert_errors++;
    end

endmodule

bind aes_top aes_chk u_chk (
  .clk_in     (clk_in),
  .rst_in     (rst_in),
  .req_ready  (req_ready),
  .resp_valid (resp_valid),
  .resp_ready (resp_ready),
  .resp       (resp)
);

`default_nettype wire

// File: tests/aes_clk_gen.sv
// testbench clock and reset source, 10 ns clock with reset held for the first four edges
`default_nettype none

module aes_clk_gen (
  output logic clk_in,
  output logic rst_in
);
  timeunit 1ns;
  timeprecision 100ps;

  // free running clock, starts low
  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  // reset high through four rising edges, released on the fourth
  initial begin
    rst_in = 1'b1;
    repeat (4) @(posedge clk_in);
    rst_in <= 1'b0;
  end

endmodule

`default_nettype wire

// File: tests/aes_tb.sv
// testbench top for the AES-128 unit, runs the FIPS-197 vectors both ways under back-pressure
`default_nettype none

module aes_tb import aes_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // ====================
  // vectors
  // ====================

  localparam int num_vectors    = 8;
  // per row core latency times four for back-pressure plus slack
  localparam int timeout_cycles = num_vectors * 24 * 4 + 100;

  // FIPS-197 appendix B
  localparam logic [127:0] key_b = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] pt_b  = 128'h3243f6a8885a308d313198a2e0370734;
  localparam logic [127:0] ct_b  = 128'h3925841d02dc09fbdc118597196a0b32;
  // FIPS-197 appendix C.1
  localparam logic [127:0] key_c = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [127:0] pt_c  = 128'h00112233445566778899aabbccddeeff;
  localparam logic [127:0] ct_c  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  typedef struct packed {
    logic         mode;
    logic [127:0] key;
    logic [127:0] din;
    logic [127:0] dout;
  } vector_t;

  vector_t                     vectors [num_vectors];
  aes_resp_t [num_vectors-1:0] expected;

  logic      clk_in;
  logic      rst_in;
  logic      req_valid;
  logic      req_ready;
  aes_req_t  req;
  logic      resp_valid;
  logic      resp_ready;
  aes_resp_t resp;

  int          resp_count;
  int          value_errors;
  int          protocol_errors;
  int          other_errors;
  int          cycle_count;
  logic        full_seen;

  aes_clk_gen u_clk_gen (
    .clk_in (clk_in),
    .rst_in (rst_in)
  );

  aes_top dut (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
  );

  aes_checker u_checker (
    .clk_in          (clk_in),
    .rst_in          (rst_in),
    .req_ready       (req_ready),
    .resp_valid      (resp_valid),
    .resp_ready      (resp_ready),
    .resp            (resp),
    .expected        (expected),
    .resp_count      (resp_count),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors),
    .full_seen       (full_seen)
  );

  // ====================
  // run control
  // ====================

  task automatic end_run(input logic timed_out);
    int total;
    total = value_errors + protocol_errors + other_errors + dut.u_chk.assert_errors;
    if (timed_out) begin
      $display("timeout after %0d cycles with %0d of %0d responses received",
               cycle_count, resp_count, num_vectors);
      total = total + 1;
    end
    $display("errors: value %0d, protocol %0d, assertion %0d, other %0d",
             value_errors, protocol_errors, dut.u_chk.assert_errors, other_errors);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // random back-pressure with ready on about half the cycles
  initial begin : back_pressure
    resp_ready = 1'b0;
    void'($urandom(32'h2085feb8));
    forever begin
      @(posedge clk_in);
      resp_ready <= ($urandom % 2) == 0;
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk_in);
      cycle_count++;
    end
    end_run(1'b1);
  end

  initial begin : stimulus
    req_valid    = 1'b0;
    req          = '0;
    other_errors = 0;

    // encrypt and decrypt rows mixed so order and mode both matter
    vectors[0] = {mode_encrypt, key_b, pt_b, ct_b};
    vectors[1] = {mode_decrypt, key_b, ct_b, pt_b};
    vectors[2] = {mode_encrypt, key_c, pt_c, ct_c};
    vectors[3] = {mode_decrypt, key_c, ct_c, pt_c};
    vectors[4] = {mode_decrypt, key_b, ct_b, pt_b};
    vectors[5] = {mode_encrypt, key_c, pt_c, ct_c};
    vectors[6] = {mode_encrypt, key_b, pt_b, ct_b};
    vectors[7] = {mode_decrypt, key_c, ct_c, pt_c};
    for (int i = 0; i < num_vectors; i++) begin
      expected[i] = {vectors[i].mode, vectors[i].dout};
    end

    // first edge with reset released
    do begin
      @(posedge clk_in);
    end while (rst_in !== 1'b0);

    // back to back requests, each held until req_ready was seen
    for (int i = 0; i < num_vectors; i++) begin
      req_valid <= 1'b1;
      req       <= {vectors[i].mode, vectors[i].din, vectors[i].key};
      do begin
        @(negedge clk_in);
      end while (!req_ready);
      @(posedge clk_in);
    end
    req_valid <= 1'b0;

    while (resp_count < num_vectors) begin
      @(posedge clk_in);
    end
    // two core latencies to let a stray extra response show up
    repeat (48) @(posedge clk_in);

    if (resp_count != num_vectors) begin
      $display("received %0d responses for %0d requests", resp_count, num_vectors);
      other_errors++;
    end
    if (!full_seen) begin
      $display("req_ready never went low while all requests were sent back to back");
      other_errors++;
    end
    end_run(1'b0);
  end

endmodule

`default_nettype wire
